/* project.f */
common/vreg_pkg.sv
vrf/vrf_bank_array.sv
vrf/vrf_read_xbar.sv
hdl/vlane_combine.sv
hdl/voperand_fetch_top.sv
dv/voperand_fetch_assertions.sv
dv/voperand_fetch_tb.sv

/* Bender.yml */
package:
  name: voperand_fetch

sources:
  # package first, then blocks bottom up
  - common/vreg_pkg.sv
  - vrf/vrf_bank_array.sv
  - vrf/vrf_read_xbar.sv
  - hdl/vlane_combine.sv
  - hdl/voperand_fetch_top.sv

  # testbench, top module voperand_fetch_tb
  - target: test
    files:
      - dv/voperand_fetch_assertions.sv
      - dv/voperand_fetch_tb.sv

/* dv/voperand_fetch_tb.sv */
/*
 * operand fetch testbench
 * random writes and issues against a shadow register file model
 */
`timescale 1ns/10ps

module voperand_fetch_tb;

    import vreg_pkg::*;

    // ========================================================================
    // run parameters
    // ========================================================================

    localparam int          CLK_PERIOD = 40;
    localparam int          RST_CYCLES = 3;
    localparam int unsigned SEED       = 32'hca01c5a1;

    // cycles spent driving each test
    localparam int N_RESET   = NUM_VREGS;
    localparam int N_SEW32   = NUM_VREGS + 24;
    localparam int N_SEW16   = NUM_VREGS + 32;
    localparam int N_SEW8    = 16;
    localparam int N_MASK    = 2 * 16;
    localparam int N_B2B     = 40;
    localparam int DRAIN_CYC = 6;  // pipe drain plus idle tail
    localparam int TIMEOUT_CYC = RST_CYCLES + N_RESET + N_SEW32 + N_SEW16 + N_SEW8
                                 + N_MASK + N_B2B + 6 * DRAIN_CYC + 50;

    // DUT ports
    logic                             clk;
    logic                             rst_n;
    logic                             wr_en;
    logic [VREG_IDX_W-1:0]            wr_vd;
    logic [NUM_BANKS-1:0]             wr_mask;
    logic [NUM_BANKS-1:0][WORD_W-1:0] wr_data;
    logic                             rd_en;
    logic [VREG_IDX_W-1:0]            vs1;
    logic [VREG_IDX_W-1:0]            vs2;
    logic [OFF_W-1:0]                 off1;
    logic [OFF_W-1:0]                 off2;
    vsew_e                            veew;
    logic                             sign_ext;
    vlane_op_e                        op;
    logic                             res_valid;
    logic [NUM_BANKS-1:0][WORD_W-1:0] res;

    // model state
    logic [NUM_BANKS-1:0][WORD_W-1:0] shadow [NUM_VREGS];  // bank k = word k of vreg
    logic [NUM_BANKS-1:0][WORD_W-1:0] exp_q [$];           // expected results, issue order
    int                               exp_cyc_q [$];       // issue cycle of each entry
    logic [NUM_BANKS-1:0][WORD_W-1:0] got_exp;
    int                               got_cyc;
    logic [VREG_IDX_W-1:0]            pair_vd;             // vreg written and read back

    // bookkeeping
    int    cyc = 0;
    string cur_test = "none";
    int    test_checks;
    int    test_errors;
    int    n_tests = 0;
    int    n_checks = 0;
    int    n_errors = 0;
    int    all_errors;

    voperand_fetch_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_vd     (wr_vd),
        .wr_mask   (wr_mask),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .vs1       (vs1),
        .vs2       (vs2),
        .off1      (off1),
        .off2      (off2),
        .veew      (veew),
        .sign_ext  (sign_ext),
        .op        (op),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================================================
    // reference model
    // ========================================================================

    // element of width w starting at bit pos of the 128-bit register
    function automatic logic [WORD_W-1:0] model_elem(
        input logic [NUM_BANKS*WORD_W-1:0] vreg,
        input int                          pos,
        input int                          w,
        input logic                        sx
    );
        logic [WORD_W-1:0] e;
        e = '0;
        for (int k = 0; k < WORD_W; k++) begin
            if (k < w) begin
                e[k] = vreg[pos + k];
            end else if (sx) begin
                e[k] = vreg[pos + w - 1];  // copy element sign
            end
        end
        return e;
    endfunction

    // lanes of one operand, elements counted across the whole register
    function automatic logic [NUM_BANKS-1:0][WORD_W-1:0] model_lanes(
        input logic [NUM_BANKS*WORD_W-1:0] vreg,
        input logic [1:0]                  sew_bits,
        input logic [OFF_W-1:0]            off,
        input logic                        sx
    );
        logic [NUM_BANKS-1:0][WORD_W-1:0] lanes;
        for (int i = 0; i < NUM_BANKS; i++) begin
            case (sew_bits)
                2'd2:    lanes[i] = vreg[i*WORD_W +: WORD_W];                     // offset ignored
                2'd1:    lanes[i] = model_elem(vreg, (int'(off[0])*4 + i) * 16, 16, sx);
                2'd0:    lanes[i] = model_elem(vreg, int'(off) * WORD_W + i * 8, 8, sx);
                default: lanes[i] = model_elem(vreg, i * 8, 8, sx);  // reserved, bank 0
            endcase
        end
        return lanes;
    endfunction

    function automatic logic [NUM_BANKS-1:0][WORD_W-1:0] model_op(
        input logic [NUM_BANKS-1:0][WORD_W-1:0] a,
        input logic [NUM_BANKS-1:0][WORD_W-1:0] b,
        input logic [1:0]                       op_bits
    );
        logic [NUM_BANKS-1:0][WORD_W-1:0] r;
        for (int i = 0; i < NUM_BANKS; i++) begin
            case (op_bits)
                2'd0:    r[i] = a[i] + b[i];
                2'd1:    r[i] = a[i] + ~b[i] + 32'd1;  // two's complement subtract
                2'd2:    r[i] = a[i] & b[i];
                default: r[i] = a[i] ^ b[i];
            endcase
        end
        return r;
    endfunction

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    function automatic logic [NUM_BANKS-1:0][WORD_W-1:0] rand_words();
        logic [NUM_BANKS-1:0][WORD_W-1:0] w;
        for (int k = 0; k < NUM_BANKS; k++) begin
            w[k] = $urandom();
        end
        return w;
    endfunction

    function automatic logic [VREG_IDX_W-1:0] rand_vreg();
        return VREG_IDX_W'($urandom_range(NUM_VREGS - 1, 0));
    endfunction

    function automatic logic [1:0] rand_two();
        return 2'($urandom_range(3, 0));
    endfunction

    function automatic logic rand_bit();
        return 1'($urandom_range(1, 0));
    endfunction

    // one falling-edge drive, model updated in the same step
    task automatic drive_cycle(
        input logic                             do_wr,
        input logic [VREG_IDX_W-1:0]            vd,
        input logic [NUM_BANKS-1:0]             mask,
        input logic [NUM_BANKS-1:0][WORD_W-1:0] data,
        input logic                             do_rd,
        input logic [VREG_IDX_W-1:0]            s1,
        input logic [VREG_IDX_W-1:0]            s2,
        input logic [OFF_W-1:0]                 o1,
        input logic [OFF_W-1:0]                 o2,
        input logic [1:0]                       sew_bits,
        input logic                             sx,
        input logic [1:0]                       op_bits
    );
        logic [NUM_BANKS-1:0][WORD_W-1:0] a;
        logic [NUM_BANKS-1:0][WORD_W-1:0] b;
        @(negedge clk);
        wr_en    = do_wr;
        wr_vd    = vd;
        wr_mask  = mask;
        wr_data  = data;
        rd_en    = do_rd;
        vs1      = s1;
        vs2      = s2;
        off1     = o1;
        off2     = o2;
        veew     = vsew_e'(sew_bits);
        sign_ext = sx;
        op       = vlane_op_e'(op_bits);
        if (do_rd) begin
            // read sees the register before this cycle's write
            a = model_lanes(shadow[s1], sew_bits, o1, sx);
            b = model_lanes(shadow[s2], sew_bits, o2, sx);
            exp_q.push_back(model_op(a, b, op_bits));
            exp_cyc_q.push_back(cyc);
        end
        if (do_wr) begin
            for (int k = 0; k < NUM_BANKS; k++) begin
                if (mask[k]) begin
                    shadow[vd][k] = data[k];
                end
            end
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0, '0, '0, 2'd2, 1'b0, 2'd0);
    endtask

    // fill every register with full-mask random data
    task automatic fill_all();
        for (int r = 0; r < NUM_VREGS; r++) begin
            drive_cycle(1'b1, VREG_IDX_W'(r), 4'hf, rand_words(), 1'b0, '0, '0, '0, '0,
                        2'd2, 1'b0, 2'd0);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    // let the pipe empty, then a short tail to catch stray results
    task automatic end_test();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        repeat (3) idle_cycle();
        $display("test %-20s checks %3d  errors %0d", cur_test, test_checks, test_errors);
        n_tests++;
        n_checks += test_checks;
        n_errors += test_errors;
    endtask

    // ========================================================================
    // result monitor and timeout
    // ========================================================================

    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: res_valid went high with no read outstanding", cur_test);
                test_errors++;
            end else begin
                got_exp = exp_q.pop_front();
                got_cyc = exp_cyc_q.pop_front();
                test_checks++;
                assert (res === got_exp) else begin
                    $display("[ERROR] %s: expected %h actual %h", cur_test, got_exp, res);
                    test_errors++;
                end
                assert (cyc - got_cyc == 2) else begin
                    $display("%s: result came %0d cycles after its read instead of 2",
                             cur_test, cyc - got_cyc);
                    test_errors++;
                end
            end
        end else if (rst_n && exp_q.size() != 0 && cyc - exp_cyc_q[0] > 2) begin
            $display("%s: no result 2 cycles after a read, result missing", cur_test);
            void'(exp_q.pop_front());
            void'(exp_cyc_q.pop_front());
            test_errors++;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        void'($urandom(SEED));  // seeds the generator for the whole run
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        wr_vd    = '0;
        wr_mask  = '0;
        wr_data  = '0;
        rd_en    = 1'b0;
        vs1      = '0;
        vs2      = '0;
        off1     = '0;
        off2     = '0;
        veew     = SEW32;
        sign_ext = 1'b0;
        op       = VOP_ADD;
        for (int r = 0; r < NUM_VREGS; r++) begin
            shadow[r] = '0;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // every register reads back zero
        start_test("reset_state");
        assert (res_valid === 1'b0 && res === '0) else begin
            $display("[ERROR] reset_state: expected valid 0 res 0 actual valid %b res %h",
                     res_valid, res);
            test_errors++;
        end
        for (int r = 0; r < NUM_VREGS; r++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, VREG_IDX_W'(r), VREG_IDX_W'(r), rand_two(),
                        rand_two(), 2'd2, 1'b0, 2'd0);
        end
        end_test();

        start_test("sew32_pass");
        fill_all();
        for (int i = 0; i < 24; i++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, rand_vreg(), rand_vreg(), rand_two(), rand_two(),
                        2'd2, rand_bit(), (i % 2 == 0) ? 2'd3 : 2'd0);  // xor, add
        end
        end_test();

        start_test("sew16_extend");
        fill_all();
        for (int i = 0; i < 32; i++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, rand_vreg(), rand_vreg(), rand_two(), rand_two(),
                        2'd1, rand_bit(), 2'(i % 4));  // cycle through all ops
        end
        end_test();

        // each offset, both extensions, sew8 and reserved width
        start_test("sew8_extend");
        for (int o = 0; o < 4; o++) begin
            for (int s = 0; s < 2; s++) begin
                drive_cycle(1'b0, '0, '0, '0, 1'b1, rand_vreg(), rand_vreg(), 2'(o), rand_two(),
                            2'd0, 1'(s), rand_two());
                drive_cycle(1'b0, '0, '0, '0, 1'b1, rand_vreg(), rand_vreg(), 2'(o), rand_two(),
                            2'd3, 1'(s), rand_two());
            end
        end
        end_test();

        start_test("masked_write_order");
        for (int i = 0; i < 16; i++) begin
            pair_vd = rand_vreg();  // target register of this pair
            drive_cycle(1'b1, pair_vd, 4'($urandom_range(14, 1)), rand_words(),
                        1'b1, pair_vd, rand_vreg(), '0, '0, 2'd2, 1'b0,
                        rand_two());
            drive_cycle(1'b0, '0, '0, '0, 1'b1, pair_vd, rand_vreg(),
                        '0, '0, 2'd2, 1'b0, rand_two());  // new data now
        end
        end_test();

        start_test("back_to_back");
        for (int i = 0; i < N_B2B; i++) begin
            drive_cycle(rand_bit(), rand_vreg(), 4'($urandom_range(15, 0)), rand_words(),
                        ($urandom_range(9, 0) != 0), rand_vreg(), rand_vreg(), rand_two(),
                        rand_two(), rand_two(), rand_bit(), rand_two());
        end
        end_test();

        all_errors = n_errors + dut_i.assert_i.fail_cnt;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, dut_i.assert_i.fail_cnt);
        if (all_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* dv/voperand_fetch_assertions.sv */
/*
 * operand fetch timing checks
 * result valid tracks issue two cycles back, result holds between pulses
 */
`timescale 1ns/10ps

module voperand_fetch_assertions (
    input logic                                                clk,
    input logic                                                rst_n,
    input logic                                                rd_en,
    input logic                                                res_valid,
    input logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] res
);

    int fail_cnt = 0;  // summed into the testbench result

    // ========================================================================
    // valid timing
    // ========================================================================

    // no result while reset is held
    reset_quiet_a: assert property (@(posedge clk) !rst_n |-> !res_valid)
        else begin
            fail_cnt++;
            $error("res_valid high during reset");
        end

    // first cycle out of reset is always quiet
    reset_exit_a: assert property (@(posedge clk) $rose(rst_n) |-> !res_valid)
        else begin
            fail_cnt++;
            $error("res_valid high right after reset");
        end

    // exactly one pulse per issue, two cycles later
    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
                                res_valid == $past(rd_en, 2))
        else begin
            fail_cnt++;
            $error("res_valid does not match rd_en two cycles earlier");
        end

    // result register only moves together with a valid pulse
    hold_a: assert property (@(posedge clk) disable iff (!rst_n) !res_valid |-> $stable(res))
        else begin
            fail_cnt++;
            $error("res changed while res_valid was low");
        end

endmodule

bind voperand_fetch_top voperand_fetch_assertions assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .res_valid (res_valid),
    .res       (res)
);

/* hdl/voperand_fetch_top.sv */
/*
 * vector operand fetch top
 * register file, two read crossbars and the lane combiner
 */
`timescale 1ns/10ps

module voperand_fetch_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    // register write
    input  logic                                                wr_en,
    input  logic [vreg_pkg::VREG_IDX_W-1:0]                     wr_vd,
    input  logic [vreg_pkg::NUM_BANKS-1:0]                      wr_mask,
    input  logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] wr_data,
    // operand issue
    input  logic                                                rd_en,
    input  logic [vreg_pkg::VREG_IDX_W-1:0]                     vs1,
    input  logic [vreg_pkg::VREG_IDX_W-1:0]                     vs2,
    input  logic [vreg_pkg::OFF_W-1:0]                          off1,
    input  logic [vreg_pkg::OFF_W-1:0]                          off2,
    input  vreg_pkg::vsew_e                                     veew,
    input  logic                                                sign_ext,
    input  vreg_pkg::vlane_op_e                                 op,
    // result, two cycles after rd_en
    output logic                                                res_valid,
    output logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] res
);

    import vreg_pkg::*;

    // stage 1 from the bank array
    vbank_word_u [NUM_BANKS-1:0]       rd1_words;
    vbank_word_u [NUM_BANKS-1:0]       rd2_words;
    logic                              q_valid;
    logic [OFF_W-1:0]                  q_off1;
    logic [OFF_W-1:0]                  q_off2;
    vsew_e                             q_veew;
    logic                              q_sign_ext;
    vlane_op_e                         q_op;

    // extended lanes into the combiner
    logic [NUM_BANKS-1:0][WORD_W-1:0]  lanes1;
    logic [NUM_BANKS-1:0][WORD_W-1:0]  lanes2;

    vrf_bank_array bank_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_vd      (wr_vd),
        .wr_mask    (wr_mask),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .vs1        (vs1),
        .vs2        (vs2),
        .off1       (off1),
        .off2       (off2),
        .veew       (veew),
        .sign_ext   (sign_ext),
        .op         (op),
        .rd1_words  (rd1_words),
        .rd2_words  (rd2_words),
        .q_valid    (q_valid),
        .q_off1     (q_off1),
        .q_off2     (q_off2),
        .q_veew     (q_veew),
        .q_sign_ext (q_sign_ext),
        .q_op       (q_op)
    );

    // vs1 path
    vrf_read_xbar xbar1_i (
        .bank_dat    (rd1_words),
        .veew        (q_veew),
        .bank_offset (q_off1),
        .sign_ext    (q_sign_ext),
        .out_dat     (lanes1)
    );

    // vs2 path, same width and extension, own offset
    vrf_read_xbar xbar2_i (
        .bank_dat    (rd2_words),
        .veew        (q_veew),
        .bank_offset (q_off2),
        .sign_ext    (q_sign_ext),
        .out_dat     (lanes2)
    );

    vlane_combine comb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (q_valid),
        .op        (q_op),
        .a_lanes   (lanes1),
        .b_lanes   (lanes2),
        .res       (res),
        .res_valid (res_valid)
    );

endmodule

/* hdl/vlane_combine.sv */
/*
 * vector lane combiner
 * applies add, sub, and or xor lane by lane to two operands
 * and registers the result with a one-cycle valid
 */
`timescale 1ns/10ps

module vlane_combine (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                in_valid,
    input  vreg_pkg::vlane_op_e                                 op,
    input  logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] a_lanes,
    input  logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] b_lanes,
    output logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] res,
    output logic                                                res_valid
);

    import vreg_pkg::*;

    // ========================================================================
    // lane arithmetic
    // ========================================================================

    logic [NUM_BANKS-1:0][WORD_W-1:0] lane_nxt;  // combinational result per lane

    // every lane runs the same op, no carries cross lanes
    always_comb begin
        for (int l = 0; l < NUM_BANKS; l++) begin
            case (op)
                VOP_ADD: lane_nxt[l] = a_lanes[l] + b_lanes[l];  // mod 2^32
                VOP_SUB: lane_nxt[l] = a_lanes[l] - b_lanes[l];  // vs1 minus vs2
                VOP_AND: lane_nxt[l] = a_lanes[l] & b_lanes[l];
                default: lane_nxt[l] = a_lanes[l] ^ b_lanes[l];  // VOP_XOR
            endcase
        end
    end

    // ========================================================================
    // result register
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= in_valid;  // single pulse per issue
            if (in_valid) begin
                res <= lane_nxt;  // held between results
            end
        end
    end

endmodule

/* vrf/vrf_read_xbar.sv */
/*
 * vector read crossbar
 * picks the element group of one vreg by width and offset
 * and extends each element into a 32-bit lane
 */
`timescale 1ns/10ps

module vrf_read_xbar (
    input  vreg_pkg::vbank_word_u [vreg_pkg::NUM_BANKS-1:0]     bank_dat,
    input  vreg_pkg::vsew_e                                     veew,
    input  logic [vreg_pkg::OFF_W-1:0]                          bank_offset,
    input  logic                                                sign_ext,
    output logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] out_dat
);

    import vreg_pkg::*;

    // ========================================================================
    // element extension
    // ========================================================================

    function automatic logic [WORD_W-1:0] ext_byte(
        input logic [BYTE_W-1:0] elem,
        input logic              sx
    );
        if (sx) begin
            return {{(WORD_W-BYTE_W){elem[BYTE_W-1]}}, elem};  // replicate msb
        end
        return {{(WORD_W-BYTE_W){1'b0}}, elem};
    endfunction

    function automatic logic [WORD_W-1:0] ext_half(
        input logic [HALF_W-1:0] elem,
        input logic              sx
    );
        if (sx) begin
            return {{(WORD_W-HALF_W){elem[HALF_W-1]}}, elem};
        end
        return {{(WORD_W-HALF_W){1'b0}}, elem};
    endfunction

    // ========================================================================
    // bank selection
    // ========================================================================

    logic [OFF_W-1:0] adj_bank_offset;  // first bank of the element group
    vbank_word_u      lo_word;          // bank at adj_bank_offset
    vbank_word_u      hi_word;          // next bank up, only sew16 uses it

    // sew8 names one bank, sew16 names a bank pair by offset bit 0
    // sew32 and the reserved code land on bank 0
    always_comb begin
        case (veew)
            SEW8:    adj_bank_offset = bank_offset;
            SEW16:   adj_bank_offset = bank_offset[0] ? 2'd2 : 2'd0;
            default: adj_bank_offset = '0;
        endcase
    end

    always_comb begin
        lo_word = bank_dat[adj_bank_offset];
        hi_word = bank_dat[adj_bank_offset + 2'd1];  // wraps for sew8 offset 3, unused then
    end

    // ========================================================================
    // lane fill
    // ========================================================================

    always_comb begin
        if (veew == SEW32) begin
            // straight through, offset has no effect
            for (int l = 0; l < NUM_BANKS; l++) begin
                out_dat[l] = bank_dat[l].word;
            end
        end else if (veew == SEW16) begin
            out_dat[0] = ext_half(lo_word.halves[0], sign_ext);  // lower bank, low half
            out_dat[1] = ext_half(lo_word.halves[1], sign_ext);
            out_dat[2] = ext_half(hi_word.halves[0], sign_ext);  // upper bank
            out_dat[3] = ext_half(hi_word.halves[1], sign_ext);
        end else begin
            // sew8 and reserved code, bytes 0..3 of a single bank
            for (int l = 0; l < NUM_BANKS; l++) begin
                out_dat[l] = ext_byte(lo_word.bytes[l], sign_ext);
            end
        end
    end

endmodule

/* vrf/vrf_bank_array.sv */
/*
 * banked vector register file
 * four banks of eight words, one masked write port, two registered reads
 * that also latch the issue control as the first pipe stage
 */
`timescale 1ns/10ps

module vrf_bank_array (
    input  logic                                                clk,
    input  logic                                                rst_n,
    // write port
    input  logic                                                wr_en,
    input  logic [vreg_pkg::VREG_IDX_W-1:0]                     wr_vd,
    input  logic [vreg_pkg::NUM_BANKS-1:0]                      wr_mask,
    input  logic [vreg_pkg::NUM_BANKS-1:0][vreg_pkg::WORD_W-1:0] wr_data,
    // issue
    input  logic                                                rd_en,
    input  logic [vreg_pkg::VREG_IDX_W-1:0]                     vs1,
    input  logic [vreg_pkg::VREG_IDX_W-1:0]                     vs2,
    input  logic [vreg_pkg::OFF_W-1:0]                          off1,
    input  logic [vreg_pkg::OFF_W-1:0]                          off2,
    input  vreg_pkg::vsew_e                                     veew,
    input  logic                                                sign_ext,
    input  vreg_pkg::vlane_op_e                                 op,
    // stage 1 outputs
    output vreg_pkg::vbank_word_u [vreg_pkg::NUM_BANKS-1:0]     rd1_words,
    output vreg_pkg::vbank_word_u [vreg_pkg::NUM_BANKS-1:0]     rd2_words,
    output logic                                                q_valid,
    output logic [vreg_pkg::OFF_W-1:0]                          q_off1,
    output logic [vreg_pkg::OFF_W-1:0]                          q_off2,
    output vreg_pkg::vsew_e                                     q_veew,
    output logic                                                q_sign_ext,
    output vreg_pkg::vlane_op_e                                 q_op
);

    import vreg_pkg::*;

    // ========================================================================
    // bank storage
    // ========================================================================

    // bank b holds word b of every vreg
    vbank_word_u bank_mem [NUM_BANKS][NUM_VREGS];

    // each bank has its own enable from wr_mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int r = 0; r < NUM_VREGS; r++) begin
                    bank_mem[b][r] <= '0;  // register file starts zeroed
                end
            end
        end else if (wr_en) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (wr_mask[b]) begin
                    bank_mem[b][wr_vd] <= wr_data[b];
                end
            end
        end
    end

    // ========================================================================
    // read stage
    // ========================================================================

    // issue valid, one cycle behind rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= rd_en;
        end
    end

    // operand words and control, captured only on an issue
    // a write in the same cycle lands after this sample, so old data is read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                rd1_words[b] <= bank_mem[b][vs1];  // vs1 operand
                rd2_words[b] <= bank_mem[b][vs2];  // vs2 operand
            end
            q_off1     <= off1;
            q_off2     <= off2;
            q_veew     <= veew;
            q_sign_ext <= sign_ext;
            q_op       <= op;
        end
    end

endmodule

/* common/vreg_pkg.sv */
/*
 * vector register package
 * sizes, element width and lane op encodings, bank word layout
 */
package vreg_pkg;

    // ========================================================================
    // register file geometry
    // ========================================================================

    localparam int WORD_W     = 32;  // one bank word
    localparam int NUM_BANKS  = 4;   // banks per vreg, also lanes per operand
    localparam int NUM_VREGS  = 8;
    localparam int VREG_IDX_W = 3;   // log2 of NUM_VREGS

    localparam int OFF_W      = 2;   // element group offset width

    // sub-word element sizes
    localparam int HALF_W     = 16;
    localparam int BYTE_W     = 8;

    // ========================================================================
    // encodings
    // ========================================================================

    // effective element width
    // value 3 is reserved and follows the sew8 path with offset 0
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vsew_e;

    // lane operation applied by the combiner
    typedef enum logic [1:0] {
        VOP_ADD = 2'd0,
        VOP_SUB = 2'd1,  // a - b, wraps mod 2^32
        VOP_AND = 2'd2,
        VOP_XOR = 2'd3
    } vlane_op_e;

    // ========================================================================
    // bank word views
    // ========================================================================

    // one bank word seen whole, as halves or as bytes
    // index 0 is always the least significant piece
    typedef union packed {
        logic [WORD_W-1:0]                      word;
        logic [WORD_W/HALF_W-1:0][HALF_W-1:0]   halves;
        logic [WORD_W/BYTE_W-1:0][BYTE_W-1:0]   bytes;
    } vbank_word_u;

endpackage
